/* include/adc_capture_defines.svh */
`ifndef ADC_CAPTURE_DEFINES_SVH
`define ADC_CAPTURE_DEFINES_SVH

// sample and packing geometry
`define SAMPLE_W   12
`define PACK_N     3

// buffer depths, fast in samples and slow in packed words
`define FAST_DEPTH 64
`define SLOW_DEPTH 64

// counter widths
`define CNT_W      16
`define DS_W       13

`endif

/* hw/capture_pkg.sv */
`include "adc_capture_defines.svh"

package capture_pkg;

    // one raw ADC sample
    typedef logic [`SAMPLE_W-1:0] sample_t;

    // capture sequencing
    typedef enum logic [2:0] {
        idle,
        presamp_filling,    // building up the presample window
        presamp_full,       // window full, oldest sample dropped per write
        triggered,
        done                // flushing leftovers from the fast FIFO
    } capture_state_t;

endpackage

/* hw/readout_pkg.sv */
`include "adc_capture_defines.svh"

package readout_pkg;

    // PACK_N samples per word, oldest sample in the top bits
    typedef logic [`PACK_N*`SAMPLE_W-1:0] word_t;

    // byte position within a readout group
    // low-res uses 0..2, hi-res uses 0..8 (two words)
    typedef logic [3:0] byte_idx_t;

endpackage

/* hw/fifo_if.sv */
interface fifo_if #(
    parameter type payload_t = logic
) ();

    logic     wr;
    payload_t din;
    logic     full;
    logic     rd;       // pops the head at the clock edge
    payload_t dout;     // head entry, valid whenever empty is low
    logic     empty;

    modport producer (
        output wr, din,
        input  full
    );

    modport consumer (
        output rd,
        input  dout, empty
    );

    modport fifo_side (
        input  wr, din, rd,
        output full, dout, empty
    );

endinterface

/* hw/sync_fifo.sv */
module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16
) (
    input  logic      adc_sampleclk,
    input  logic      reset,
    fifo_if.fifo_side fifo
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = fifo.wr & ~fifo.full;     // write ignored while full
    assign do_rd = fifo.rd & ~fifo.empty;    // read ignored while empty

    assign fifo.full  = (count == DEPTH);
    assign fifo.empty = (count == '0);
    assign fifo.dout  = mem[rd_ptr];         // first word fall through

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= fifo.din;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or simultaneous push and pop
            endcase
        end
    end

    // count stays within DEPTH and agrees with the pointer distance
    a_count_bound: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (count <= DEPTH) &&
        (int'(wr_ptr) == (int'(rd_ptr) + int'(count)) % DEPTH));

endmodule

/* hw/capture_ctrl.sv */
`include "adc_capture_defines.svh"

module capture_ctrl
    import capture_pkg::*;
(
    input  logic              adc_sampleclk,
    input  logic              reset,
    input  sample_t           adc_data_i,
    input  logic              adc_write_mask_i,
    input  logic              arm_i,
    input  logic              capture_go_i,
    input  logic [`CNT_W-1:0] presample_i,
    input  logic [`CNT_W-1:0] max_samples_i,
    input  logic [`DS_W-1:0]  downsample_i,
    fifo_if.producer          fast_wr,
    fifo_if.consumer          fast_rd,
    output sample_t           sample_o,
    output logic              sample_valid_o,
    output logic              capture_stop_o
);

    capture_state_t    state;
    logic              arm_r;
    logic              arm_rise;
    logic              armed;
    logic [`DS_W-1:0]  ds_cnt;
    logic              ds_strobe;
    logic [`CNT_W-1:0] pre_cnt;
    logic [`CNT_W-1:0] fwd_cnt;
    logic              capture_en;
    logic              accept;
    logic              fwd;
    logic              discard;
    logic              drain;

    assign arm_rise  = arm_i & ~arm_r;
    assign ds_strobe = (ds_cnt == '0);    // first cycle after each wrap

    assign capture_en = (state == presamp_filling) || (state == presamp_full) ||
                        (state == triggered);
    assign accept  = ds_strobe & adc_write_mask_i & capture_en & ~fast_wr.full;
    assign fwd     = accept & (state == triggered) & ~fast_rd.empty;
    assign discard = accept & (state == presamp_full);  // keeps window length fixed
    assign drain   = (state == done) & ~fast_rd.empty;

    assign fast_wr.wr  = accept;
    assign fast_wr.din = adc_data_i;
    assign fast_rd.rd  = fwd | discard | drain;

    // head of the fast FIFO goes straight to the packer
    assign sample_o       = fast_rd.dout;
    assign sample_valid_o = fwd;

    // decimation restarts on each arm edge
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r  <= 1'b0;
            ds_cnt <= '0;
        end else begin
            arm_r <= arm_i;
            if (arm_rise || (ds_cnt >= downsample_i)) begin
                ds_cnt <= '0;
            end else begin
                ds_cnt <= ds_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state          <= idle;
            armed          <= 1'b0;
            pre_cnt        <= '0;
            fwd_cnt        <= '0;
            capture_stop_o <= 1'b0;
        end else begin
            if (arm_rise) begin
                armed          <= 1'b1;
                capture_stop_o <= 1'b0;  // stop holds until the next arm
            end
            case (state)
                idle: begin
                    pre_cnt <= '0;
                    fwd_cnt <= '0;
                    if (arm_rise || armed) begin
                        if (presample_i != '0) begin
                            state <= presamp_filling;
                            armed <= 1'b0;
                        end else if (capture_go_i) begin
                            state <= triggered;
                            armed <= 1'b0;
                        end
                    end
                end
                presamp_filling: begin
                    if (accept) begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                    if (capture_go_i) begin
                        state <= triggered;
                    end else if (accept && (pre_cnt + 1'b1 == presample_i)) begin
                        state <= presamp_full;  // window complete with this write
                    end
                end
                presamp_full: begin
                    if (capture_go_i) begin
                        state <= triggered;
                    end
                end
                triggered: begin
                    if (fwd) begin
                        fwd_cnt <= fwd_cnt + 1'b1;
                        if (fwd_cnt + 1'b1 == max_samples_i) begin
                            capture_stop_o <= 1'b1;
                            state          <= done;
                        end
                    end
                end
                done: begin
                    if (fast_rd.empty) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // no sample on the strobe is lost to a full fast FIFO during capture
    a_fast_no_overrun: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (ds_strobe && adc_write_mask_i && capture_en) |-> !fast_wr.full);

    // once full, the presample window never runs dry
    a_window_kept: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (state == presamp_full) |-> !fast_rd.empty);

endmodule

/* hw/word_packer.sv */
`include "adc_capture_defines.svh"

module word_packer
    import capture_pkg::*;
    import readout_pkg::*;
(
    input  logic     adc_sampleclk,
    input  logic     reset,
    input  sample_t  sample_i,
    input  logic     sample_valid_i,
    fifo_if.producer slow_wr
);

    localparam int GRP_W  = $clog2(`PACK_N);
    localparam int WORD_W = $bits(word_t);

    word_t             word_r;
    logic [GRP_W-1:0]  grp_cnt;
    logic [`CNT_W-1:0] gap_cnt;
    logic              wr_r;

    assign slow_wr.wr  = wr_r;
    assign slow_wr.din = word_r;

    // newest sample enters at the bottom
    always_ff @(posedge adc_sampleclk) begin
        if (sample_valid_i) begin
            word_r <= {word_r[WORD_W-`SAMPLE_W-1:0], sample_i};
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            grp_cnt <= '0;
            gap_cnt <= '0;
            wr_r    <= 1'b0;
        end else begin
            wr_r <= 1'b0;
            if (sample_valid_i) begin
                gap_cnt <= '0;
                if (grp_cnt == GRP_W'(`PACK_N - 1)) begin
                    grp_cnt <= '0;
                    wr_r    <= 1'b1;    // word goes out next cycle
                end else begin
                    grp_cnt <= grp_cnt + 1'b1;
                end
            end else if (gap_cnt != '1) begin
                gap_cnt <= gap_cnt + 1'b1;
            end else begin
                grp_cnt <= '0;  // capture over, partial group dropped
            end
        end
    end

    a_slow_no_drop: assert property (@(posedge adc_sampleclk) disable iff (reset)
        slow_wr.wr |-> !slow_wr.full)
        else $error("slow FIFO full, packed word dropped");

endmodule

/* hw/byte_readout.sv */
`include "adc_capture_defines.svh"

module byte_readout
    import readout_pkg::*;
(
    input  logic       adc_sampleclk,
    input  logic       reset,
    input  logic       low_res_i,
    input  logic       low_res_lsb_i,
    input  logic       read_en_i,
    fifo_if.consumer   slow_rd,
    output logic [7:0] read_data_o,
    output logic       read_empty_o
);

    localparam byte_idx_t LO_LAST = byte_idx_t'(`PACK_N - 1);
    localparam byte_idx_t HI_MID  = byte_idx_t'(3);   // first word ends mid byte
    localparam byte_idx_t HI_LAST = byte_idx_t'(8);

    byte_idx_t            idx;
    logic [3:0]           nib_r;
    logic                 take;
    logic                 pop;
    logic [`SAMPLE_W-1:0] lo_smp;

    assign read_empty_o = slow_rd.empty;
    assign take         = read_en_i & ~slow_rd.empty;  // empty FIFO holds the index
    assign pop          = low_res_i ? (idx == LO_LAST) : ((idx == HI_MID) || (idx == HI_LAST));
    assign slow_rd.rd   = take & pop;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            idx <= '0;
        end else if (take) begin
            if (low_res_i ? (idx >= LO_LAST) : (idx >= HI_LAST)) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // low nibble of the last sample in the first word
    always_ff @(posedge adc_sampleclk) begin
        if (take && !low_res_i && (idx == HI_MID)) begin
            nib_r <= slow_rd.dout[3:0];
        end
    end

    always_comb begin
        int lo_pos;
        lo_pos = `PACK_N - 1 - int'(idx);
        lo_smp = slow_rd.dout[lo_pos*`SAMPLE_W +: `SAMPLE_W];
        if (low_res_i) begin
            read_data_o = low_res_lsb_i ? lo_smp[7:0] : lo_smp[`SAMPLE_W-1 -: 8];
        end else begin
            case (idx)
                4'd0:    read_data_o = slow_rd.dout[35:28];
                4'd1:    read_data_o = slow_rd.dout[27:20];
                4'd2:    read_data_o = slow_rd.dout[19:12];
                4'd3:    read_data_o = slow_rd.dout[11:4];
                4'd4:    read_data_o = {nib_r, slow_rd.dout[35:32]};  // straddles two words
                4'd5:    read_data_o = slow_rd.dout[31:24];
                4'd6:    read_data_o = slow_rd.dout[23:16];
                4'd7:    read_data_o = slow_rd.dout[15:8];
                4'd8:    read_data_o = slow_rd.dout[7:0];
                default: read_data_o = 8'h00;
            endcase
        end
    end

endmodule

/* hw/adc_capture_top.sv */
`include "adc_capture_defines.svh"

module adc_capture_top
    import capture_pkg::*;
    import readout_pkg::*;
(
    input  logic              adc_sampleclk,
    input  logic              reset,
    input  sample_t           adc_data_i,
    input  logic              adc_write_mask_i,
    input  logic              arm_i,
    input  logic              capture_go_i,
    output logic              capture_stop_o,
    input  logic [`CNT_W-1:0] presample_i,
    input  logic [`CNT_W-1:0] max_samples_i,
    input  logic [`DS_W-1:0]  downsample_i,
    input  logic              low_res_i,
    input  logic              low_res_lsb_i,
    input  logic              read_en_i,
    output logic [7:0]        read_data_o,
    output logic              read_empty_o
);

    sample_t fwd_sample;
    logic    fwd_valid;

    fifo_if #(.payload_t(sample_t)) fast_if ();
    fifo_if #(.payload_t(word_t))   slow_if ();

    capture_ctrl u_capture_ctrl (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .adc_data_i       (adc_data_i),
        .adc_write_mask_i (adc_write_mask_i),
        .arm_i            (arm_i),
        .capture_go_i     (capture_go_i),
        .presample_i      (presample_i),
        .max_samples_i    (max_samples_i),
        .downsample_i     (downsample_i),
        .fast_wr          (fast_if.producer),
        .fast_rd          (fast_if.consumer),
        .sample_o         (fwd_sample),
        .sample_valid_o   (fwd_valid),
        .capture_stop_o   (capture_stop_o)
    );

    sync_fifo #(.payload_t(sample_t), .DEPTH(`FAST_DEPTH)) u_fast_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .fifo          (fast_if.fifo_side)
    );

    word_packer u_word_packer (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .sample_i       (fwd_sample),
        .sample_valid_i (fwd_valid),
        .slow_wr        (slow_if.producer)
    );

    sync_fifo #(.payload_t(word_t), .DEPTH(`SLOW_DEPTH)) u_slow_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .fifo          (slow_if.fifo_side)
    );

    byte_readout u_byte_readout (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .low_res_i     (low_res_i),
        .low_res_lsb_i (low_res_lsb_i),
        .read_en_i     (read_en_i),
        .slow_rd       (slow_if.consumer),
        .read_data_o   (read_data_o),
        .read_empty_o  (read_empty_o)
    );

endmodule

/* verif/tb_adc_capture.sv */
`include "adc_capture_defines.svh"

module tb_adc_capture
    import capture_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_RUNS   = 9;

    logic              adc_sampleclk = 1'b0;
    logic              reset;
    sample_t           adc_data_i;
    logic              adc_write_mask_i;
    logic              arm_i;
    logic              capture_go_i;
    logic              capture_stop_o;
    logic [`CNT_W-1:0] presample_i;
    logic [`CNT_W-1:0] max_samples_i;
    logic [`DS_W-1:0]  downsample_i;
    logic              low_res_i;
    logic              low_res_lsb_i;
    logic              read_en_i;
    logic [7:0]        read_data_o;
    logic              read_empty_o;

    int seed;
    int data_errors;
    int ctrl_errors;
    int budget_cycles = 0;

    // per run configuration
    // mode 0 low-res msb, 1 low-res lsb, 2 hi-res
    int   run_pre   [NUM_RUNS];
    int   run_max   [NUM_RUNS];
    int   run_ds    [NUM_RUNS];
    int   run_delay [NUM_RUNS];
    int   run_mode  [NUM_RUNS];
    logic run_full_mask [NUM_RUNS];

    // reference model state
    sample_t    pre_q[$];    // pre-trigger window
    sample_t    post_q[$];   // accepted after trigger
    logic [7:0] exp_bytes[$];
    int         ds_m;
    int         occ_m;       // fast FIFO occupancy
    int         fwd_m;
    logic       active_m;
    logic       trig_m;
    logic       armed_m;
    logic       arm_prev_m;

    always #(CLK_PERIOD/2) adc_sampleclk = ~adc_sampleclk;

    adc_capture_top u_adc_capture_top (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .adc_data_i       (adc_data_i),
        .adc_write_mask_i (adc_write_mask_i),
        .arm_i            (arm_i),
        .capture_go_i     (capture_go_i),
        .capture_stop_o   (capture_stop_o),
        .presample_i      (presample_i),
        .max_samples_i    (max_samples_i),
        .downsample_i     (downsample_i),
        .low_res_i        (low_res_i),
        .low_res_lsb_i    (low_res_lsb_i),
        .read_en_i        (read_en_i),
        .read_data_o      (read_data_o),
        .read_empty_o     (read_empty_o)
    );

    task automatic choose_runs();
        int total;
        int nbytes;
        total = 8;  // reset
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_mode[r]      = r % 3;
            run_ds[r]        = (r < 3) ? 0 : 1 + ($unsigned($random(seed)) % 3);
            run_pre[r]       = (r == 0 || r == 4) ? 0 : 1 + ($unsigned($random(seed)) % 20);
            run_max[r]       = 6 * (1 + ($unsigned($random(seed)) % 8));  // whole hi-res groups
            run_delay[r]     = $unsigned($random(seed)) % 30;
            run_full_mask[r] = (r < 2);
            nbytes = (run_mode[r] == 2) ? run_max[r] * 3 / 2 : run_max[r];
            total += 10 + run_delay[r] + `FAST_DEPTH + nbytes * 4 +
                     (run_pre[r] + run_max[r] + 2) * (run_ds[r] + 1) * 4;
        end
        budget_cycles = total;
    endtask

    task automatic drive_sample(input int r);
        adc_data_i       <= sample_t'($random(seed));
        adc_write_mask_i <= run_full_mask[r] ? 1'b1 : (($random(seed) & 3) != 0);
    endtask

    // advances the model one clock on the inputs of the cycle just ended
    task automatic mirror_cycle(input int p);
        logic arm_rise;
        arm_rise = arm_i & ~arm_prev_m;
        if (active_m && ds_m == 0 && adc_write_mask_i) begin
            if (trig_m) begin
                post_q.push_back(adc_data_i);
                if (occ_m > 0) begin
                    fwd_m++;
                end else begin
                    occ_m++;    // read of an empty FIFO is ignored
                end
            end else begin
                pre_q.push_back(adc_data_i);
                if (pre_q.size() > p) begin
                    void'(pre_q.pop_front());
                end
                if (occ_m < p) begin
                    occ_m++;
                end
            end
        end
        if (arm_rise || ds_m >= int'(downsample_i)) begin
            ds_m = 0;
        end else begin
            ds_m++;
        end
        if (!active_m) begin
            if (arm_rise || armed_m) begin
                armed_m = 1'b1;
                if (p != 0) begin
                    active_m = 1'b1;
                    armed_m  = 1'b0;
                end else if (capture_go_i) begin
                    active_m = 1'b1;
                    trig_m   = 1'b1;
                    armed_m  = 1'b0;
                end
            end
        end else if (capture_go_i) begin
            trig_m = 1'b1;
        end
        arm_prev_m = arm_i;
    endtask

    task automatic capture_run(input int r);
        int   delay;
        logic exp_stop;
        delay = run_delay[r];
        pre_q.delete();
        post_q.delete();
        occ_m      = 0;
        fwd_m      = 0;
        ds_m       = 0;
        active_m   = 1'b0;
        trig_m     = 1'b0;
        armed_m    = 1'b0;
        arm_prev_m = 1'b0;
        @(posedge adc_sampleclk);
        presample_i   <= run_pre[r][`CNT_W-1:0];
        max_samples_i <= run_max[r][`CNT_W-1:0];
        downsample_i  <= run_ds[r][`DS_W-1:0];
        low_res_i     <= (run_mode[r] != 2);
        low_res_lsb_i <= (run_mode[r] == 1);
        arm_i         <= 1'b1;
        @(posedge adc_sampleclk);
        mirror_cycle(run_pre[r]);   // arm edge cycle
        arm_i <= 1'b0;
        drive_sample(r);
        forever begin
            @(posedge adc_sampleclk);
            exp_stop = (fwd_m >= run_max[r]);
            assert (capture_stop_o === exp_stop) else begin
                ctrl_errors++;
                $display("MISMATCH capture_stop_o: expected %h, got %h",
                         exp_stop, capture_stop_o);
            end
            if (capture_stop_o || exp_stop) begin
                break;
            end
            mirror_cycle(run_pre[r]);
            drive_sample(r);
            if (occ_m >= run_pre[r] && !capture_go_i) begin    // window full
                if (delay == 0) begin
                    capture_go_i <= 1'b1;
                end else begin
                    delay--;
                end
            end
        end
        capture_go_i     <= 1'b0;
        adc_write_mask_i <= 1'b0;
    endtask

    task automatic build_expected(input int r);
        sample_t                  s;
        logic [6*`SAMPLE_W-1:0]   grp;
        int                       npre;
        npre = pre_q.size();
        exp_bytes.delete();
        grp = '0;
        assert (npre + post_q.size() >= run_max[r]) else begin
            ctrl_errors++;
            $display("run %0d captured only %0d samples, fewer than max_samples_i",
                     r, npre + post_q.size());
        end
        for (int i = 0; i < run_max[r] && i < npre + post_q.size(); i++) begin
            s = (i < npre) ? pre_q[i] : post_q[i - npre];
            if (run_mode[r] == 0) begin
                exp_bytes.push_back(s[`SAMPLE_W-1 -: 8]);
            end else if (run_mode[r] == 1) begin
                exp_bytes.push_back(s[7:0]);
            end else begin
                grp = {grp[5*`SAMPLE_W-1:0], s};   // msb first
                if (i % 6 == 5) begin
                    for (int b = 0; b < 9; b++) begin
                        exp_bytes.push_back(grp[6*`SAMPLE_W-1-8*b -: 8]);
                    end
                end
            end
        end
    endtask

    task automatic read_and_check();
        int got;
        got = 0;
        while (got < exp_bytes.size()) begin
            @(posedge adc_sampleclk);
            if (read_en_i && !read_empty_o) begin
                assert (read_data_o === exp_bytes[got]) else begin
                    data_errors++;
                    $display("MISMATCH read_data_o byte %0d: expected %h, got %h",
                             got, exp_bytes[got], read_data_o);
                end
                got++;
            end
            read_en_i <= (got < exp_bytes.size()) && (($random(seed) & 3) != 0);
        end
        @(posedge adc_sampleclk);
        assert (read_empty_o === 1'b1) else begin
            ctrl_errors++;
            $display("MISMATCH read_empty_o: expected %h, got %h", 1'b1, read_empty_o);
        end
    endtask

    initial begin
        seed             = 32'h16914d22;
        reset            = 1'b1;
        adc_data_i       = '0;
        adc_write_mask_i = 1'b0;
        arm_i            = 1'b0;
        capture_go_i     = 1'b0;
        presample_i      = '0;
        max_samples_i    = '0;
        downsample_i     = '0;
        low_res_i        = 1'b1;
        low_res_lsb_i    = 1'b0;
        read_en_i        = 1'b0;
        data_errors      = 0;
        ctrl_errors      = 0;
        choose_runs();
        repeat (8) @(posedge adc_sampleclk);
        reset <= 1'b0;
        for (int r = 0; r < NUM_RUNS; r++) begin
            capture_run(r);
            build_expected(r);
            read_and_check();
            repeat (`FAST_DEPTH) @(posedge adc_sampleclk);  // let the fast FIFO drain
        end
        $display("error counts: data %0d, control %0d", data_errors, ctrl_errors);
        if (data_errors + ctrl_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (budget_cycles != 0);
        #(budget_cycles * 2 * CLK_PERIOD);
        $display("watchdog expired, run took longer than %0d cycles", budget_cycles * 2);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* adc_capture_top.f */
+incdir+include
hw/capture_pkg.sv
hw/readout_pkg.sv
hw/fifo_if.sv
hw/sync_fifo.sv
hw/capture_ctrl.sv
hw/word_packer.sv
hw/byte_readout.sv
hw/adc_capture_top.sv
verif/tb_adc_capture.sv

/* run_sim.sh */
#!/bin/sh
# build and run the capture buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_adc_capture \
    -f adc_capture_top.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only if the testbench printed its pass line
grep -qx "Done: no errors" "$LOG" || exit 1
exit 0
